//--- page_alloc.f
verilog/alloc_cfg_pkg.sv
verilog/alloc_types_pkg.sv
verilog/page_free_map.sv
verilog/usecnt_table.sv
verilog/alloc_ctrl.sv
verilog/page_allocator.sv
sim/page_alloc_assert.sv
sim/tb_page_allocator.sv

//--- run_sim.sh
#!/bin/sh
# build the page allocator testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_page_allocator \
   -f page_alloc.f -o tb_sim > build.log 2>&1 \
   && ./obj_dir/tb_sim > sim.log 2>&1 \
   || { echo "build or simulation run failed, see build.log and sim.log"; exit 1; }

grep -q "Finished with no errors" sim.log \
   && echo "simulation passed" \
   || { echo "simulation failed, see sim.log"; exit 1; }

//--- sim/page_alloc_assert.sv
`timescale 1ns/1ns

module page_alloc_assert (
   input logic                        clk,
   input logic                        rst_n_i,
   input logic                        req_valid_i,
   input logic                        req_ready_i,
   input logic                        rsp_valid_i,
   input logic                        rsp_ready_i,
   input alloc_types_pkg::alloc_rsp_t rsp_i
);

   // a pending response must not move
   a_rsp_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
      rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_i))
      else $error("response changed or dropped before it was accepted");

   // accept at N, response valid from edge N+1
   a_rsp_after_req: assert property (@(posedge clk) disable iff (!rst_n_i)
      $past(req_valid_i && req_ready_i, 2) |-> rsp_valid_i)
      else $error("no response one edge after a request handshake");

   a_rsp_has_req: assert property (@(posedge clk) disable iff (!rst_n_i)
      $rose(rsp_valid_i) |-> $past(req_valid_i && req_ready_i, 2))
      else $error("response raised without a request handshake");

   // one request in flight at a time
   a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n_i)
      !(req_ready_i && rsp_valid_i))
      else $error("request ready while a response is pending");

endmodule

bind page_allocator page_alloc_assert u_assert (
   .clk         (clk),
   .rst_n_i     (rst_n_i),
   .req_valid_i (req_valid_i),
   .req_ready_i (req_ready_o),
   .rsp_valid_i (rsp_valid_o),
   .rsp_ready_i (rsp_ready_i),
   .rsp_i       (rsp_o)
);

//--- sim/tb_page_allocator.sv
`timescale 1ns/1ns

module tb_page_allocator;
   import alloc_cfg_pkg::*;
   import alloc_types_pkg::*;

   localparam int TIMEOUT_CYC = 200;

   typedef struct packed {
      alloc_rsp_t            rsp;
      logic [FREE_CNT_W-1:0] free_cnt;   // free pages once this request is done
   } expect_t;

   logic                  clk;
   logic                  rst_n;
   logic                  req_valid;
   logic                  req_ready;
   alloc_req_t            req;
   logic                  rsp_valid;
   logic                  rsp_ready;
   alloc_rsp_t            rsp;
   logic [FREE_CNT_W-1:0] free_cnt;

   logic                  model_busy [NUM_PAGES];
   logic [USECNT_W-1:0]   model_cnt  [NUM_PAGES];
   int                    model_free;
   expect_t               exp_q [$];
   string                 name_q [$];   // test name per outstanding request
   string                 test_name;
   logic [TAG_W-1:0]      tag_ctr;
   bit                    random_bp;
   int                    rsp_errors;
   int                    cnt_errors;
   int                    other_errors;

   page_allocator u_dut (
      .clk         (clk),
      .rst_n_i     (rst_n),
      .req_valid_i (req_valid),
      .req_ready_o (req_ready),
      .req_i       (req),
      .rsp_valid_o (rsp_valid),
      .rsp_ready_i (rsp_ready),
      .rsp_o       (rsp),
      .free_cnt_o  (free_cnt)
   );

   always #10 clk = ~clk;

   // reference model, updates the page state and returns the expected response
   function automatic alloc_rsp_t model_apply(input alloc_req_t r);
      alloc_rsp_t e;
      int         idx;
      e.status   = ST_OK;
      e.tag      = r.tag;
      e.page     = r.page;
      e.last_use = 1'b0;
      idx        = -1;
      if (r.op == OP_ALLOC) begin
         for (int i = 0; i < NUM_PAGES; i++) begin
            if (!model_busy[i]) begin
               idx = i;   // lowest free page
               break;
            end
         end
         if (idx < 0) begin
            e.status = ST_NOMEM;
            e.page   = '0;
         end else begin
            model_busy[idx] = 1'b1;
            model_cnt[idx]  = r.usecnt;
            model_free--;
            e.page = PAGE_W'(idx);
         end
      end else if (!model_busy[r.page]) begin
         e.status = ST_NOT_ALLOC;
      end else begin
         case (r.op)
            OP_FREE: begin
               if (model_cnt[r.page] > 1) begin
                  model_cnt[r.page] = model_cnt[r.page] - 1'b1;
               end else begin
                  model_cnt[r.page]  = '0;   // count 1 or 0 is the last user
                  model_busy[r.page] = 1'b0;
                  model_free++;
                  e.last_use = 1'b1;
               end
            end
            OP_FORCE_FREE: begin
               model_cnt[r.page]  = '0;
               model_busy[r.page] = 1'b0;
               model_free++;
               e.last_use = 1'b1;
            end
            default: begin
               model_cnt[r.page] = r.usecnt;
            end
         endcase
      end
      return e;
   endfunction

   always @(negedge clk) begin
      if (random_bp) begin
         rsp_ready = ($urandom_range(3) != 0);   // ready 3 cycles in 4
      end else begin
         rsp_ready = 1'b1;
      end
   end

   // compare every transferred response with the model
   always @(posedge clk) begin
      expect_t e;
      string   nm;
      if (rst_n && rsp_valid && rsp_ready) begin
         assert (exp_q.size() > 0) else begin
            other_errors++;
            $display("response with tag %0d arrived but no request was pending", rsp.tag);
         end
         if (exp_q.size() > 0) begin
            e  = exp_q.pop_front();
            nm = name_q.pop_front();
            assert (rsp == e.rsp) else begin
               rsp_errors++;
               $write("ERR %s: rsp expected st=%0d tag=%0d page=%0d last=%0d",
                  nm, e.rsp.status, e.rsp.tag, e.rsp.page, e.rsp.last_use);
               $display(" actual st=%0d tag=%0d page=%0d last=%0d",
                  rsp.status, rsp.tag, rsp.page, rsp.last_use);
            end
            assert (free_cnt == e.free_cnt) else begin
               cnt_errors++;
               $display("ERR %s: free_cnt expected %0d actual %0d", nm, e.free_cnt, free_cnt);
            end
         end
      end
   end

   task automatic print_counts();
      $display("errors: response %0d, free count %0d, other %0d",
         rsp_errors, cnt_errors, other_errors);
   endtask

   task automatic abort_run(input string why);
      other_errors++;
      $display("timeout: %s", why);
      print_counts();
      $display("Finished with errors");
      $finish;
   endtask

   // called right after a falling edge, returns right after one
   task automatic send(input alloc_op_e op, input logic [PAGE_W-1:0] page,
                       input logic [USECNT_W-1:0] usecnt);
      alloc_req_t r;
      expect_t    e;
      int         waited;
      r.op       = op;
      r.tag      = tag_ctr;
      r.page     = page;
      r.usecnt   = usecnt;
      tag_ctr    = tag_ctr + 1'b1;
      e.rsp      = model_apply(r);
      e.free_cnt = FREE_CNT_W'(model_free);
      exp_q.push_back(e);
      name_q.push_back(test_name);
      req       = r;
      req_valid = 1'b1;
      waited    = 0;
      @(posedge clk);
      while (!req_ready && waited < TIMEOUT_CYC) begin
         waited++;
         @(posedge clk);
      end
      if (!req_ready) begin
         abort_run("request was never accepted");
      end else begin
         @(negedge clk);
         req_valid = 1'b0;
      end
   endtask

   task automatic drain();
      int waited;
      waited = 0;
      while (exp_q.size() != 0 && waited < TIMEOUT_CYC) begin
         @(negedge clk);
         waited++;
      end
      if (exp_q.size() != 0) begin
         abort_run("a response never arrived");
      end
   endtask

   task automatic check_free(input int exp_free);
      assert (free_cnt == FREE_CNT_W'(exp_free)) else begin
         cnt_errors++;
         $display("ERR %s: free_cnt expected %0d actual %0d", test_name, exp_free, free_cnt);
      end
   endtask

   initial begin
      alloc_op_e           op;
      logic [PAGE_W-1:0]   pg;
      logic [USECNT_W-1:0] uc;
      void'($urandom(19953));
      clk          = 1'b0;
      rst_n        = 1'b0;
      req_valid    = 1'b0;
      req          = '0;
      rsp_ready    = 1'b0;
      random_bp    = 1'b0;
      tag_ctr      = '0;
      rsp_errors   = 0;
      cnt_errors   = 0;
      other_errors = 0;
      model_free   = NUM_PAGES;
      for (int i = 0; i < NUM_PAGES; i++) begin
         model_busy[i] = 1'b0;
         model_cnt[i]  = '0;
      end
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      test_name = "reset";
      check_free(NUM_PAGES);
      assert (req_ready == 1'b1) else begin
         other_errors++;
         $display("ERR %s: req_ready expected 1 actual %0d", test_name, req_ready);
      end
      assert (rsp_valid == 1'b0) else begin
         other_errors++;
         $display("ERR %s: rsp_valid expected 0 actual %0d", test_name, rsp_valid);
      end

      test_name = "alloc_order";   // pages 0, 1, 2
      repeat (3) send(OP_ALLOC, '0, 4'd1);
      drain();

      test_name = "fill";
      repeat (61) send(OP_ALLOC, '0, 4'd1);
      send(OP_ALLOC, '0, 4'd1);   // nothing left
      drain();
      check_free(0);

      test_name = "multi_use";
      send(OP_FREE, 6'd5, '0);
      send(OP_ALLOC, '0, 4'd3);   // reuses page 5
      repeat (3) send(OP_FREE, 6'd5, '0);
      drain();

      test_name = "set_usecnt";
      send(OP_ALLOC, '0, 4'd0);
      send(OP_SET_USECNT, 6'd5, 4'd2);
      repeat (2) send(OP_FREE, 6'd5, '0);
      send(OP_SET_USECNT, 6'd9, 4'd7);
      send(OP_FORCE_FREE, 6'd9, '0);
      drain();

      test_name = "not_alloc";
      send(OP_FREE, 6'd9, '0);
      send(OP_FORCE_FREE, 6'd5, '0);
      send(OP_SET_USECNT, 6'd9, 4'd3);
      send(OP_ALLOC, '0, 4'd1);   // page 5 must still be the first free
      drain();

      test_name = "random";
      random_bp = 1'b1;
      repeat (2000) begin
         op = alloc_op_e'($urandom_range(3));
         pg = PAGE_W'($urandom_range(NUM_PAGES - 1));
         uc = USECNT_W'($urandom_range(15));
         send(op, pg, uc);
      end
      drain();
      random_bp = 1'b0;
      check_free(model_free);

      print_counts();
      if (rsp_errors + cnt_errors + other_errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

//--- verilog/alloc_cfg_pkg.sv
package alloc_cfg_pkg;

   // buffer geometry
   localparam int NUM_PAGES  = 64;
   localparam int PAGE_W     = 6;   // page address bits

   localparam int USECNT_W   = 4;   // max use count 15
   localparam int TAG_W      = 5;   // requester tag

   // holds 0..NUM_PAGES inclusive
   localparam int FREE_CNT_W = 7;

endpackage

//--- verilog/alloc_ctrl.sv
`timescale 1ns/1ns

module alloc_ctrl (
   input  logic                               clk,
   input  logic                               rst_n_i,
   // request channel
   input  logic                               req_valid_i,
   output logic                               req_ready_o,
   input  alloc_types_pkg::alloc_req_t        req_i,
   // response channel
   output logic                               rsp_valid_o,
   input  logic                               rsp_ready_i,
   output alloc_types_pkg::alloc_rsp_t        rsp_o,
   // page map
   input  logic                               page_busy_i,
   input  logic [alloc_cfg_pkg::PAGE_W-1:0]   first_free_i,
   input  logic                               empty_i,
   output logic [alloc_cfg_pkg::PAGE_W-1:0]   map_page_o,
   output logic                               take_o,
   output logic                               release_o,
   // use-count table
   input  logic                               last_i,
   output alloc_types_pkg::cnt_op_e           cnt_cmd_o,
   output logic [alloc_cfg_pkg::PAGE_W-1:0]   cnt_page_o,
   output logic [alloc_cfg_pkg::USECNT_W-1:0] cnt_val_o
);
   import alloc_types_pkg::*;

   ctrl_state_e state_q;
   ctrl_state_e state_d;
   alloc_req_t  req_q;     // request under execution
   alloc_rsp_t  rsp_q;
   alloc_rsp_t  rsp_d;
   logic        req_fire;
   logic        rsp_fire;

   assign req_ready_o = (state_q == S_IDLE);
   assign rsp_valid_o = (state_q == S_RESP);
   assign req_fire    = req_valid_i & req_ready_o;
   assign rsp_fire    = rsp_valid_o & rsp_ready_i;

   assign rsp_o      = rsp_q;
   assign map_page_o = req_q.page;

   // alloc works on the first free page, everything else on the request page
   assign cnt_page_o = (req_q.op == OP_ALLOC) ? first_free_i : req_q.page;

   always_comb begin
      state_d = state_q;
      case (state_q)
         S_IDLE: begin
            if (req_fire) begin
               state_d = S_EXEC;
            end
         end
         S_EXEC: begin
            state_d = S_RESP;   // single cycle of work
         end
         S_RESP: begin
            if (rsp_fire) begin
               state_d = S_IDLE;
            end
         end
         default: begin
            state_d = S_IDLE;
         end
      endcase
   end

   // update commands and response, only acted on in S_EXEC
   always_comb begin
      take_o         = 1'b0;
      release_o      = 1'b0;
      cnt_cmd_o      = CNT_HOLD;
      cnt_val_o      = req_q.usecnt;
      rsp_d.status   = ST_OK;
      rsp_d.tag      = req_q.tag;
      rsp_d.page     = req_q.page;
      rsp_d.last_use = 1'b0;

      if (state_q == S_EXEC) begin
         if (req_q.op == OP_ALLOC) begin
            if (empty_i) begin
               rsp_d.status = ST_NOMEM;
               rsp_d.page   = '0;
            end else begin
               take_o     = 1'b1;
               cnt_cmd_o  = CNT_LOAD;
               rsp_d.page = first_free_i;
            end
         end else if (!page_busy_i) begin
            rsp_d.status = ST_NOT_ALLOC;   // nothing is touched
         end else begin
            case (req_q.op)
               OP_FREE: begin
                  cnt_cmd_o      = CNT_DEC;
                  release_o      = last_i;
                  rsp_d.last_use = last_i;
               end
               OP_FORCE_FREE: begin
                  cnt_cmd_o      = CNT_LOAD;   // count back to zero
                  cnt_val_o      = '0;
                  release_o      = 1'b1;
                  rsp_d.last_use = 1'b1;
               end
               default: begin
                  cnt_cmd_o = CNT_LOAD;        // set_usecnt
               end
            endcase
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= S_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   always_ff @(posedge clk) begin
      if (req_fire) begin
         req_q <= req_i;
      end
      if (state_q == S_EXEC) begin
         rsp_q <= rsp_d;   // held until the response transfers
      end
   end

endmodule

//--- verilog/alloc_types_pkg.sv
package alloc_types_pkg;

   // request opcodes
   typedef enum logic [1:0] {
      OP_ALLOC      = 2'd0,
      OP_FREE       = 2'd1,
      OP_FORCE_FREE = 2'd2,
      OP_SET_USECNT = 2'd3
   } alloc_op_e;

   typedef enum logic [1:0] {
      ST_OK        = 2'd0,
      ST_NOMEM     = 2'd1,   // no free page left
      ST_NOT_ALLOC = 2'd2    // page was not allocated
   } alloc_status_e;

   // use-count table commands
   typedef enum logic [1:0] {
      CNT_HOLD = 2'd0,
      CNT_LOAD = 2'd1,
      CNT_DEC  = 2'd2
   } cnt_op_e;

   typedef enum logic [1:0] {
      S_IDLE = 2'd0,
      S_EXEC = 2'd1,
      S_RESP = 2'd2
   } ctrl_state_e;

   typedef struct packed {
      alloc_op_e                           op;
      logic [alloc_cfg_pkg::TAG_W-1:0]     tag;
      logic [alloc_cfg_pkg::PAGE_W-1:0]    page;    // ignored by alloc
      logic [alloc_cfg_pkg::USECNT_W-1:0]  usecnt;  // alloc and set_usecnt only
   } alloc_req_t;

   typedef struct packed {
      alloc_status_e                       status;
      logic [alloc_cfg_pkg::TAG_W-1:0]     tag;
      logic [alloc_cfg_pkg::PAGE_W-1:0]    page;
      logic                                last_use;
   } alloc_rsp_t;

endpackage

//--- verilog/page_allocator.sv
`timescale 1ns/1ns

module page_allocator (
   input  logic                                clk,
   input  logic                                rst_n_i,
   input  logic                                req_valid_i,
   output logic                                req_ready_o,
   input  alloc_types_pkg::alloc_req_t         req_i,
   output logic                                rsp_valid_o,
   input  logic                                rsp_ready_i,
   output alloc_types_pkg::alloc_rsp_t         rsp_o,
   output logic [alloc_cfg_pkg::FREE_CNT_W-1:0] free_cnt_o
);
   import alloc_cfg_pkg::*;
   import alloc_types_pkg::*;

   logic                page_busy;
   logic [PAGE_W-1:0]   first_free;
   logic                empty;
   logic [PAGE_W-1:0]   map_page;
   logic                take_pg;
   logic                release_pg;
   logic                last;
   cnt_op_e             cnt_cmd;
   logic [PAGE_W-1:0]   cnt_page;
   logic [USECNT_W-1:0] cnt_val;

   alloc_ctrl u_ctrl (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .req_valid_i  (req_valid_i),
      .req_ready_o  (req_ready_o),
      .req_i        (req_i),
      .rsp_valid_o  (rsp_valid_o),
      .rsp_ready_i  (rsp_ready_i),
      .rsp_o        (rsp_o),
      .page_busy_i  (page_busy),
      .first_free_i (first_free),
      .empty_i      (empty),
      .map_page_o   (map_page),
      .take_o       (take_pg),
      .release_o    (release_pg),
      .last_i       (last),
      .cnt_cmd_o    (cnt_cmd),
      .cnt_page_o   (cnt_page),
      .cnt_val_o    (cnt_val)
   );

   page_free_map u_map (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .take_i       (take_pg),
      .release_i    (release_pg),
      .page_i       (map_page),
      .page_busy_o  (page_busy),
      .first_free_o (first_free),
      .empty_o      (empty),
      .free_cnt_o   (free_cnt_o)
   );

   usecnt_table u_cnt (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .cmd_i   (cnt_cmd),
      .page_i  (cnt_page),
      .cnt_i   (cnt_val),
      .count_o (),
      .last_o  (last)
   );

endmodule

//--- verilog/page_free_map.sv
`timescale 1ns/1ns

module page_free_map (
   input  logic                                clk,
   input  logic                                rst_n_i,
   input  logic                                take_i,
   input  logic                                release_i,
   input  logic [alloc_cfg_pkg::PAGE_W-1:0]     page_i,
   output logic                                page_busy_o,
   output logic [alloc_cfg_pkg::PAGE_W-1:0]     first_free_o,
   output logic                                empty_o,
   output logic [alloc_cfg_pkg::FREE_CNT_W-1:0] free_cnt_o
);
   import alloc_cfg_pkg::*;

   logic [NUM_PAGES-1:0]  busy_q;      // one bit per page, 1 = allocated
   logic [PAGE_W-1:0]     first_free;
   logic [FREE_CNT_W-1:0] free_cnt_q;

   // lowest free page wins, scan from the top so the last hit is the lowest
   always_comb begin
      first_free = '0;
      for (int i = NUM_PAGES - 1; i >= 0; i--) begin
         if (!busy_q[i]) begin
            first_free = PAGE_W'(i);
         end
      end
   end

   assign page_busy_o  = busy_q[page_i];
   assign first_free_o = first_free;
   assign empty_o      = &busy_q;
   assign free_cnt_o   = free_cnt_q;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         busy_q <= '0;
      end else begin
         if (take_i) begin
            busy_q[first_free] <= 1'b1;
         end
         if (release_i) begin
            busy_q[page_i] <= 1'b0;   // never the page being taken
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         free_cnt_q <= FREE_CNT_W'(NUM_PAGES);
      end else begin
         if (take_i && !release_i) begin
            free_cnt_q <= free_cnt_q - 1'b1;
         end else if (release_i && !take_i) begin
            free_cnt_q <= free_cnt_q + 1'b1;
         end
      end
   end

endmodule

//--- verilog/usecnt_table.sv
`timescale 1ns/1ns

module usecnt_table (
   input  logic                               clk,
   input  logic                               rst_n_i,
   input  alloc_types_pkg::cnt_op_e           cmd_i,
   input  logic [alloc_cfg_pkg::PAGE_W-1:0]   page_i,
   input  logic [alloc_cfg_pkg::USECNT_W-1:0] cnt_i,
   output logic [alloc_cfg_pkg::USECNT_W-1:0] count_o,
   output logic                               last_o
);
   import alloc_cfg_pkg::*;
   import alloc_types_pkg::*;

   logic [USECNT_W-1:0] cnt_q [NUM_PAGES];

   // combinational read of the addressed entry
   assign count_o = cnt_q[page_i];

   // a free at 1 or 0 is the final user of the page
   assign last_o = (count_o <= USECNT_W'(1));

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < NUM_PAGES; i++) begin
            cnt_q[i] <= '0;
         end
      end else begin
         case (cmd_i)
            CNT_LOAD: begin
               cnt_q[page_i] <= cnt_i;
            end
            CNT_DEC: begin
               if (count_o != '0) begin   // saturate at zero
                  cnt_q[page_i] <= count_o - 1'b1;
               end
            end
            default: begin
               // CNT_HOLD
            end
         endcase
      end
   end

endmodule
